// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int ADDR_SIZE   = 32;
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_SIZE = 4;
    localparam int TAG_SIZE    = ADDR_SIZE - OFFSET_SIZE;  // Line address.
    localparam int LINE_SIZE   = LINE_BYTES * 8;
    localparam int WORD_SIZE   = 32;
    localparam int LINE_WORDS  = LINE_SIZE / WORD_SIZE;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } dcache_op_e;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } dcache_size_e;

    // Stores write through the byte view; loads and memory use words.
    typedef union packed {
        logic [LINE_BYTES-1:0][7:0]           bytes;
        logic [LINE_WORDS-1:0][WORD_SIZE-1:0] words;
    } dcache_line_u;

endpackage : dcache_pkg

`default_nettype wire

// File: verilog/dcache_req_decode.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_req_decode import dcache_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_i,
    input  dcache_op_e             op_i,
    input  dcache_size_e           size_i,
    input  logic                   signed_i,
    input  logic [ADDR_SIZE-1:0]   addr_i,
    input  logic [WORD_SIZE-1:0]   wdata_i,
    input  logic                   busy_i,
    output logic                   lookup_o,
    output logic [TAG_SIZE-1:0]    tag_o,
    output logic [OFFSET_SIZE-1:0] offset_o,
    output dcache_op_e             op_o,
    output dcache_size_e           size_o,
    output logic                   signed_o,
    output logic [WORD_SIZE-1:0]   wdata_o,
    output logic                   err_o
);

    logic accept;
    logic misaligned;

    assign accept     = req_i && !busy_i;
    assign misaligned = (size_i == SIZE_WORD) && (addr_i[1:0] != 2'b00);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lookup_o <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            lookup_o <= accept && !misaligned;
            err_o    <= accept && misaligned;  // Rejected, nothing else changes.
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && !misaligned) begin
            tag_o    <= addr_i[ADDR_SIZE-1:OFFSET_SIZE];
            offset_o <= addr_i[OFFSET_SIZE-1:0];
            op_o     <= op_i;
            size_o   <= size_i;
            signed_o <= signed_i;
            wdata_o  <= wdata_i;
        end
    end

    // Requester must respect back-pressure from the miss handling.
    a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(req_i && busy_i));

endmodule : dcache_req_decode

`default_nettype wire

// File: verilog/dcache_tag.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag import dcache_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    lookup_i,
    input  logic [TAG_SIZE-1:0]                     tag_i,
    input  logic                                    refill_i,
    input  logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] refill_lane_i,
    input  logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] victim_lane_i,
    input  logic                                    mark_dirty_i,
    input  logic                                    invalidate_i,
    output logic                                    hit_o,
    output logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] hit_lane_o,
    output logic                                    victim_dirty_o,
    output logic [TAG_SIZE-1:0]                     victim_addr_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] valid_q;
    logic [NUM_LANES-1:0] dirty_q;
    logic [TAG_SIZE-1:0]  tags_q [NUM_LANES];
    logic [NUM_LANES-1:0] hit_vector;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (invalidate_i) begin
                valid_q <= '0;
                dirty_q <= '0;  // Dirty data is dropped.
            end
            if (mark_dirty_i) begin
                dirty_q[hit_lane_o] <= 1'b1;
            end
            if (refill_i) begin
                valid_q[refill_lane_i] <= 1'b1;
                dirty_q[refill_lane_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            tags_q[refill_lane_i] <= tag_i;
        end
    end

    always_comb begin
        hit_lane_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            hit_vector[i] = valid_q[i] && (tags_q[i] == tag_i);
            if (hit_vector[i]) begin
                hit_lane_o = LANE_W'(i);  // One-hot to binary.
            end
        end
    end

    assign hit_o          = (|hit_vector) && lookup_i;
    assign victim_dirty_o = valid_q[victim_lane_i] && dirty_q[victim_lane_i];
    assign victim_addr_o  = tags_q[victim_lane_i];

    // Refill only ever fills a line that missed, so no duplicates.
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(hit_vector));

endmodule : dcache_tag

`default_nettype wire

// File: verilog/dcache_data.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data import dcache_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                                         clk_i,
    input  logic                                         refill_i,
    input  logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] refill_lane_i,
    input  logic [LINE_SIZE-1:0]                         refill_line_i,
    input  logic                                         store_i,
    input  logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] hit_lane_i,
    input  logic [OFFSET_SIZE-1:0]                       offset_i,
    input  dcache_size_e                                 size_i,
    input  logic [WORD_SIZE-1:0]                         wdata_i,
    input  logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] victim_lane_i,
    output dcache_line_u                                 hit_line_o,
    output logic [LINE_SIZE-1:0]                         victim_line_o
);

    dcache_line_u               lines_q [NUM_LANES];
    logic [LINE_BYTES-1:0]      be;
    logic [LINE_BYTES-1:0][7:0] wbytes;

    always_comb begin
        be = '0;
        if (size_i == SIZE_WORD) begin
            be[{offset_i[OFFSET_SIZE-1:2], 2'b00} +: 4] = 4'hF;
        end else begin
            be[offset_i] = 1'b1;
        end
    end

    // Replicate so every enabled byte finds its data in place.
    assign wbytes = (size_i == SIZE_WORD) ? {LINE_WORDS{wdata_i}}
                                          : {LINE_BYTES{wdata_i[7:0]}};

    always_ff @(posedge clk_i) begin
        if (refill_i) begin
            lines_q[refill_lane_i] <= refill_line_i;
        end else if (store_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (be[i]) begin
                    lines_q[hit_lane_i].bytes[i] <= wbytes[i];
                end
            end
        end
    end

    assign hit_line_o    = lines_q[hit_lane_i];
    assign victim_line_o = lines_q[victim_lane_i];  // Write-back payload.

endmodule : dcache_data

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl import dcache_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                                         clk_i,
    input  logic                                         rst_n_i,
    input  logic                                         lookup_i,
    input  dcache_op_e                                   op_i,
    input  logic                                         hit_i,
    input  logic                                         victim_dirty_i,
    input  logic                                         mem_ack_i,
    output logic                                         busy_o,
    output logic                                         hit_o,
    output logic                                         miss_o,
    output logic                                         rsp_valid_o,
    output logic                                         store_o,
    output logic                                         mark_dirty_o,
    output logic                                         refill_o,
    output logic [(NUM_LANES>1?$clog2(NUM_LANES):1)-1:0] victim_lane_o,
    output logic                                         mem_rd_o,
    output logic                                         mem_wr_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_RD,
        ST_RETRY
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [LANE_W-1:0] rr_q;
    logic              miss;
    logic              outstanding_q;

    assign hit_o  = (state_q == ST_IDLE) && lookup_i && hit_i;
    assign miss   = (state_q == ST_IDLE) && lookup_i && !hit_i;
    assign miss_o = miss;
    assign busy_o = miss || (state_q == ST_WB) || (state_q == ST_RD);

    // Retry always hits since the line was just filled.
    assign rsp_valid_o  = hit_o || (state_q == ST_RETRY);
    assign store_o      = rsp_valid_o && (op_i == OP_STORE);
    assign mark_dirty_o = store_o;
    assign refill_o     = (state_q == ST_RD) && mem_ack_i;

    assign victim_lane_o = rr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty_i ? ST_WB : ST_RD;
                end
            end
            ST_WB: begin
                if (mem_ack_i) begin
                    state_d = ST_RD;
                end
            end
            ST_RD: begin
                if (mem_ack_i) begin
                    state_d = ST_RETRY;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= ST_IDLE;
            rr_q          <= '0;
            mem_rd_o      <= 1'b0;
            mem_wr_o      <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            mem_wr_o <= (state_q == ST_IDLE) && (state_d == ST_WB);  // One pulse per entry.
            mem_rd_o <= (state_q != ST_RD) && (state_d == ST_RD);
            if (refill_o) begin
                rr_q <= (rr_q == LANE_W'(NUM_LANES - 1)) ? '0 : rr_q + 1'b1;
            end
            if (mem_rd_o || mem_wr_o) begin
                outstanding_q <= 1'b1;
            end else if (mem_ack_i) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    a_one_mem_txn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_rd_o || mem_wr_o) |-> !outstanding_q);

endmodule : dcache_ctrl

`default_nettype wire

// File: verilog/dcache_load_align.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_load_align import dcache_pkg::*; (
    input  dcache_line_u           hit_line_i,
    input  logic [OFFSET_SIZE-1:0] offset_i,
    input  dcache_size_e           size_i,
    input  logic                   signed_i,
    output logic [WORD_SIZE-1:0]   rdata_o
);

    logic [WORD_SIZE-1:0] word_sel;
    logic [7:0]           byte_sel;
    logic                 ext_bit;

    assign word_sel = hit_line_i.words[offset_i[OFFSET_SIZE-1:2]];
    assign byte_sel = hit_line_i.bytes[offset_i];
    assign ext_bit  = signed_i && byte_sel[7];  // Zero unless signed.

    always_comb begin
        if (size_i == SIZE_WORD) begin
            rdata_o = word_sel;
        end else begin
            rdata_o = {{(WORD_SIZE-8){ext_bit}}, byte_sel};
        end
    end

endmodule : dcache_load_align

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  dcache_op_e           op_i,
    input  dcache_size_e         size_i,
    input  logic                 signed_i,
    input  logic [ADDR_SIZE-1:0] addr_i,
    input  logic [WORD_SIZE-1:0] wdata_i,
    input  logic                 invalidate_i,
    output logic                 busy_o,
    output logic                 rsp_valid_o,
    output logic [WORD_SIZE-1:0] rdata_o,
    output logic                 hit_o,
    output logic                 miss_o,
    output logic                 err_o,
    output logic                 mem_rd_o,
    output logic                 mem_wr_o,
    output logic [TAG_SIZE-1:0]  mem_addr_o,
    output logic [LINE_SIZE-1:0] mem_wdata_o,
    input  logic [LINE_SIZE-1:0] mem_rdata_i,
    input  logic                 mem_ack_i
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic                   lookup;
    logic [TAG_SIZE-1:0]    req_tag;
    logic [OFFSET_SIZE-1:0] req_offset;
    dcache_op_e             req_op;
    dcache_size_e           req_size;
    logic                   req_signed;
    logic [WORD_SIZE-1:0]   req_wdata;
    logic                   tag_hit;
    logic [LANE_W-1:0]      hit_lane;
    logic                   victim_dirty;
    logic [TAG_SIZE-1:0]    victim_addr;
    logic [LANE_W-1:0]      victim_lane;
    logic                   refill;
    logic                   store;
    logic                   mark_dirty;
    dcache_line_u           hit_line;

    assign mem_addr_o = mem_wr_o ? victim_addr : req_tag;  // Write-back or refill address.

    dcache_req_decode u_decode (
        .clk_i, .rst_n_i, .req_i, .op_i, .size_i, .signed_i, .addr_i, .wdata_i,
        .busy_i(busy_o), .lookup_o(lookup), .tag_o(req_tag), .offset_o(req_offset),
        .op_o(req_op), .size_o(req_size), .signed_o(req_signed), .wdata_o(req_wdata),
        .err_o
    );

    dcache_tag #(.NUM_LANES(NUM_LANES)) u_tag (
        .clk_i, .rst_n_i, .lookup_i(lookup), .tag_i(req_tag), .refill_i(refill),
        .refill_lane_i(victim_lane), .victim_lane_i(victim_lane),
        .mark_dirty_i(mark_dirty), .invalidate_i(invalidate_i && !busy_o),
        .hit_o(tag_hit), .hit_lane_o(hit_lane), .victim_dirty_o(victim_dirty),
        .victim_addr_o(victim_addr)
    );

    dcache_data #(.NUM_LANES(NUM_LANES)) u_data (
        .clk_i, .refill_i(refill), .refill_lane_i(victim_lane), .refill_line_i(mem_rdata_i),
        .store_i(store), .hit_lane_i(hit_lane), .offset_i(req_offset), .size_i(req_size),
        .wdata_i(req_wdata), .victim_lane_i(victim_lane), .hit_line_o(hit_line),
        .victim_line_o(mem_wdata_o)
    );

    dcache_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
        .clk_i, .rst_n_i, .lookup_i(lookup), .op_i(req_op), .hit_i(tag_hit),
        .victim_dirty_i(victim_dirty), .mem_ack_i, .busy_o, .hit_o, .miss_o, .rsp_valid_o,
        .store_o(store), .mark_dirty_o(mark_dirty), .refill_o(refill),
        .victim_lane_o(victim_lane), .mem_rd_o, .mem_wr_o
    );

    dcache_load_align u_align (
        .hit_line_i(hit_line), .offset_i(req_offset), .size_i(req_size),
        .signed_i(req_signed), .rdata_o
    );

endmodule : dcache_top

`default_nettype wire

// File: verif/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_checker import dcache_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_i,
    input  dcache_op_e           op_i,
    input  dcache_size_e         size_i,
    input  logic [ADDR_SIZE-1:0] addr_i,
    input  logic [WORD_SIZE-1:0] wdata_i,
    input  logic                 invalidate_i,
    input  logic                 busy_i,
    input  logic                 rsp_valid_i,
    input  logic [WORD_SIZE-1:0] rdata_i,
    input  logic                 hit_i,
    input  logic                 miss_i,
    input  logic                 err_i,
    input  logic                 mem_rd_i,
    input  logic                 mem_wr_i,
    input  logic [TAG_SIZE-1:0]  mem_addr_i,
    input  logic [LINE_SIZE-1:0] mem_wdata_i,
    input  logic [WORD_SIZE-1:0] exp_rdata_i,
    output int                   checks_o,
    output int                   errors_o
);

    logic [TAG_SIZE-1:0]  ref_tag   [NUM_LANES];
    logic [LINE_SIZE-1:0] ref_line  [NUM_LANES];
    logic                 ref_valid [NUM_LANES];
    logic                 ref_dirty [NUM_LANES];
    logic [7:0]           ref_mem   [int unsigned];
    int                   rr;
    logic                 lookup_pend;
    logic                 err_pend;
    logic                 wb_pend;
    logic                 rd_pend;
    logic                 rsp_pend;
    logic [TAG_SIZE-1:0]  wb_addr;
    logic [TAG_SIZE-1:0]  rd_addr;
    logic [LINE_SIZE-1:0] wb_line;
    dcache_op_e           cur_op;
    dcache_size_e         cur_size;
    logic [ADDR_SIZE-1:0] cur_addr;
    logic [WORD_SIZE-1:0] cur_wdata;

    function automatic logic [7:0] init_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;  // Untouched memory.
    endfunction

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return init_byte(a);
    endfunction

    task automatic compare(input string name, input logic [LINE_SIZE-1:0] got,
                           input logic [LINE_SIZE-1:0] exp);
        checks_o++;
        if (got !== exp) begin
            errors_o++;
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic fail(input string what);
        errors_o++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic lookup_line();
        int                  lane;
        int                  off;
        logic [TAG_SIZE-1:0] tag;
        tag  = cur_addr[ADDR_SIZE-1:OFFSET_SIZE];
        lane = -1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ref_valid[i] && ref_tag[i] == tag) begin
                lane = i;
            end
        end
        compare("hit_o", LINE_SIZE'(hit_i), LINE_SIZE'(lane >= 0));
        compare("miss_o", LINE_SIZE'(miss_i), LINE_SIZE'(lane < 0));
        compare("rsp_valid_o", LINE_SIZE'(rsp_valid_i), LINE_SIZE'(lane >= 0));
        compare("busy_o", LINE_SIZE'(busy_i), LINE_SIZE'(lane < 0));
        rsp_pend = 1'b1;
        if (lane < 0) begin
            lane = rr;
            if (ref_valid[lane] && ref_dirty[lane]) begin
                wb_pend = 1'b1;
                wb_addr = ref_tag[lane];
                wb_line = ref_line[lane];
                for (int i = 0; i < LINE_BYTES; i++) begin
                    ref_mem[{wb_addr, 4'h0} + i] = wb_line[8*i +: 8];
                end
            end
            rd_pend = 1'b1;
            rd_addr = tag;
            for (int i = 0; i < LINE_BYTES; i++) begin
                ref_line[lane][8*i +: 8] = mem_byte({tag, 4'h0} + i);
            end
            ref_tag[lane]   = tag;
            ref_valid[lane] = 1'b1;
            ref_dirty[lane] = 1'b0;
            rr              = (rr + 1) % NUM_LANES;  // Round robin.
        end
        if (cur_op == OP_STORE) begin
            off = int'(cur_addr[OFFSET_SIZE-1:0]);
            if (cur_size == SIZE_WORD) begin
                ref_line[lane][8*off +: 32] = cur_wdata;
            end else begin
                ref_line[lane][8*off +: 8] = cur_wdata[7:0];
            end
            ref_dirty[lane] = 1'b1;
        end
    endtask

    initial begin
        checks_o = 0;
        errors_o = 0;
    end

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                ref_valid[i] = 1'b0;
                ref_dirty[i] = 1'b0;
            end
            rr          = 0;
            lookup_pend = 1'b0;
            err_pend    = 1'b0;
            wb_pend     = 1'b0;
            rd_pend     = 1'b0;
            rsp_pend    = 1'b0;
        end else begin
            if (err_pend) begin
                compare("err_o", LINE_SIZE'(err_i), LINE_SIZE'(1));
            end else if (err_i) begin
                fail("err_o raised for an aligned access");
            end
            err_pend = 1'b0;
            if (lookup_pend) begin
                lookup_line();
            end else if (hit_i || miss_i) begin
                fail("hit_o or miss_o raised without a lookup");
            end
            lookup_pend = 1'b0;
            if (mem_wr_i) begin
                if (!wb_pend) begin
                    fail("write-back issued for a clean or absent victim");
                end else begin
                    compare("mem_addr_o", LINE_SIZE'(mem_addr_i), LINE_SIZE'(wb_addr));
                    compare("mem_wdata_o", mem_wdata_i, wb_line);
                end
                wb_pend = 1'b0;
            end
            if (mem_rd_i) begin
                if (wb_pend) begin
                    fail("refill read issued before the write-back");
                end
                if (!rd_pend) begin
                    fail("refill read issued without a miss");
                end
                compare("mem_addr_o", LINE_SIZE'(mem_addr_i), LINE_SIZE'(rd_addr));
                rd_pend = 1'b0;
            end
            if (rsp_valid_i) begin
                if (!rsp_pend) begin
                    fail("rsp_valid_o raised without a pending request");
                end else if (cur_op == OP_LOAD) begin
                    compare("rdata_o", LINE_SIZE'(rdata_i), LINE_SIZE'(exp_rdata_i));
                end
                rsp_pend = 1'b0;
            end
            if (invalidate_i && !busy_i) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    ref_valid[i] = 1'b0;
                    ref_dirty[i] = 1'b0;  // Dropped, never written.
                end
            end
            if (req_i && !busy_i) begin
                cur_op    = op_i;
                cur_size  = size_i;
                cur_addr  = addr_i;
                cur_wdata = wdata_i;
                if (size_i == SIZE_WORD && addr_i[1:0] != 2'b00) begin
                    err_pend = 1'b1;
                end else begin
                    lookup_pend = 1'b1;
                end
            end
        end
    end

endmodule : dcache_checker

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 req_i;
    dcache_op_e           op_i;
    dcache_size_e         size_i;
    logic                 signed_i;
    logic [ADDR_SIZE-1:0] addr_i;
    logic [WORD_SIZE-1:0] wdata_i;
    logic                 invalidate_i;
    logic                 busy_o;
    logic                 rsp_valid_o;
    logic [WORD_SIZE-1:0] rdata_o;
    logic                 hit_o;
    logic                 miss_o;
    logic                 err_o;
    logic                 mem_rd_o;
    logic                 mem_wr_o;
    logic [TAG_SIZE-1:0]  mem_addr_o;
    logic [LINE_SIZE-1:0] mem_wdata_o;
    logic [LINE_SIZE-1:0] mem_rdata_i;
    logic                 mem_ack_i;
    logic [WORD_SIZE-1:0] exp_rdata;
    int                   checks;
    int                   errors;

    logic [31:0]          st_op    [$];
    logic [31:0]          st_size  [$];
    logic [31:0]          st_sign  [$];
    logic [31:0]          st_addr  [$];
    logic [31:0]          st_wdata [$];
    logic [31:0]          st_exp   [$];
    logic [7:0]           mem_q    [int unsigned];
    logic [TAG_SIZE-1:0]  mem_line_addr;
    logic                 mem_pending;
    int unsigned          mem_wait;
    int                   cycles;
    int                   limit;
    logic                 stim_ok;

    dcache_top #(.NUM_LANES(4)) dut (
        .clk_i, .rst_n_i, .req_i, .op_i, .size_i, .signed_i, .addr_i, .wdata_i,
        .invalidate_i, .busy_o, .rsp_valid_o, .rdata_o, .hit_o, .miss_o, .err_o,
        .mem_rd_o, .mem_wr_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i, .mem_ack_i
    );

    dcache_checker #(.NUM_LANES(4)) u_checker (
        .clk_i, .rst_n_i, .req_i, .op_i, .size_i, .addr_i, .wdata_i, .invalidate_i,
        .busy_i(busy_o), .rsp_valid_i(rsp_valid_o), .rdata_i(rdata_o), .hit_i(hit_o),
        .miss_i(miss_o), .err_i(err_o), .mem_rd_i(mem_rd_o), .mem_wr_i(mem_wr_o),
        .mem_addr_i(mem_addr_o), .mem_wdata_i(mem_wdata_o), .exp_rdata_i(exp_rdata),
        .checks_o(checks), .errors_o(errors)
    );

    function automatic logic [7:0] init_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Line-wide memory that acks 1 to 6 cycles after each strobe.
    always @(negedge clk_i) begin
        mem_ack_i = 1'b0;
        if (mem_pending) begin
            if (mem_wait == 0) begin
                for (int i = 0; i < LINE_BYTES; i++) begin
                    if (mem_q.exists({mem_line_addr, 4'h0} + i)) begin
                        mem_rdata_i[8*i +: 8] = mem_q[{mem_line_addr, 4'h0} + i];
                    end else begin
                        mem_rdata_i[8*i +: 8] = init_byte({mem_line_addr, 4'h0} + i);
                    end
                end
                mem_ack_i   = 1'b1;
                mem_pending = 1'b0;
            end else begin
                mem_wait--;
            end
        end
        if (mem_rd_o || mem_wr_o) begin
            if (mem_wr_o) begin
                for (int i = 0; i < LINE_BYTES; i++) begin
                    mem_q[{mem_addr_o, 4'h0} + i] = mem_wdata_o[8*i +: 8];
                end
            end
            mem_line_addr = mem_addr_o;
            mem_pending   = 1'b1;
            mem_wait      = $urandom % 6;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run did not end within %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic load_stim(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [6];
        fd = $fopen("verif/dcache_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5]);
                    if (n == 6) begin
                        st_op.push_back(f[0]);
                        st_size.push_back(f[1]);
                        st_sign.push_back(f[2]);
                        st_addr.push_back(f[3]);
                        st_wdata.push_back(f[4]);
                        st_exp.push_back(f[5]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_access(input int i);
        while (busy_o) begin
            @(negedge clk_i);
        end
        if (st_op[i] == 32'd2) begin
            invalidate_i = 1'b1;
            @(negedge clk_i);
            invalidate_i = 1'b0;
        end else begin
            op_i      = dcache_op_e'(st_op[i][0]);
            size_i    = dcache_size_e'(st_size[i][0]);
            signed_i  = st_sign[i][0];
            addr_i    = st_addr[i];
            wdata_i   = st_wdata[i];
            exp_rdata = st_exp[i];
            req_i     = 1'b1;
            @(negedge clk_i);
            req_i = 1'b0;
            while (!rsp_valid_o && !err_o) begin  // Hit, miss or reject.
                @(negedge clk_i);
            end
        end
        @(negedge clk_i);
    endtask

    initial begin
        void'($urandom(38452));
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        op_i         = OP_LOAD;
        size_i       = SIZE_WORD;
        signed_i     = 1'b0;
        addr_i       = '0;
        wdata_i      = '0;
        invalidate_i = 1'b0;
        mem_rdata_i  = '0;
        mem_ack_i    = 1'b0;
        mem_pending  = 1'b0;
        mem_wait     = 0;
        exp_rdata    = '0;
        cycles       = 0;
        limit        = 0;
        load_stim(stim_ok);
        if (stim_ok) begin
            limit = st_op.size() * 20 + 100;
            repeat (5) @(negedge clk_i);
            rst_n_i = 1'b1;
            for (int i = 0; i < st_op.size(); i++) begin
                run_access(i);
            end
            repeat (4) @(negedge clk_i);
        end else begin
            $display("error: cannot open verif/dcache_stim.txt");
        end
        $display("accesses %0d, checks %0d, errors %0d", st_op.size(), checks, errors);
        if (stim_ok && errors == 0 && st_op.size() > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : dcache_tb

`default_nettype wire

// File: verif/dcache_stim.txt
# op(0 load, 1 store, 2 invalidate) size(0 byte, 1 word) signed addr wdata expected_rdata
# All fields hex; expected_rdata is only compared for loads.
0 1 0 00000100 00000000 58595A5B
0 1 0 00000104 00000000 5C5D5E5F
0 0 0 0000010F 00000000 00000054
0 0 1 00000180 00000000 FFFFFFDB
0 0 0 00000181 00000000 000000DA
1 1 0 00000108 DEADBEEF 00000000
0 1 0 00000108 00000000 DEADBEEF
1 0 0 0000010D 00000077 00000000
0 1 0 0000010C 00000000 54557757
0 0 1 0000010D 00000000 00000077
0 1 0 00000200 00000000 5B5A5958
1 1 0 00000300 12345678 00000000
0 1 0 00000400 00000000 5D5C5F5E
0 1 0 00000500 00000000 5C5D5E5F
0 1 0 00000108 00000000 DEADBEEF
0 0 0 0000010D 00000000 00000077
0 1 0 00000300 00000000 12345678
0 1 0 00000302 00000000 00000000
0 1 0 00000304 00000000 5E5F5C5D
1 1 0 00000106 FFFFFFFF 00000000
0 1 0 00000104 00000000 5C5D5E5F
1 1 0 00000500 CAFEF00D 00000000
2 0 0 00000000 00000000 00000000
0 1 0 00000500 00000000 5C5D5E5F
0 1 0 00000300 00000000 5A5B5859
0 1 0 00000100 00000000 58595A5B
0 1 0 00000108 00000000 DEADBEEF
1 0 0 00000101 000000A5 00000000
0 0 1 00000101 00000000 FFFFFFA5
0 1 0 00000100 00000000 5859A55B
0 1 0 00000200 00000000 5B5A5958
0 1 0 00000400 00000000 5D5C5F5E
0 1 0 00000180 00000000 D8D9DADB
0 1 0 00000500 00000000 5C5D5E5F
0 0 0 00000101 00000000 000000A5

// File: src.f
verilog/dcache_pkg.sv
verilog/dcache_req_decode.sv
verilog/dcache_tag.sv
verilog/dcache_data.sv
verilog/dcache_ctrl.sv
verilog/dcache_load_align.sv
verilog/dcache_top.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f src.f -o dcache_sim
	./obj_dir/dcache_sim | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module dcache_tb -f src.f

clean:
	rm -rf obj_dir sim.log
